//--- design/core_config.svh
// Core configuration
// Datapath widths, register file size and the first fetch address

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data and address width
`define CORE_XLEN 32

// Integer register file
`define CORE_NUM_REGS 32
`define CORE_REG_ADDR_W 5

// First fetch after reset
`define CORE_RESET_VECTOR 32'h0008_0000

`endif

//--- design/core_pkg.sv
// Core package
// Instruction views, decode enums and the bus and control structs

`include "core_config.svh"

package core_pkg;

  // ------------------------------
  // Instruction word
  // ------------------------------

  // Same 32 bits, R-type or S/B-type field split
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
  } inst_u;

  // Supported major opcodes
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_fn_e;

  // Encoded as the load funct3
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_kind_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_LINK
  } wb_sel_e;

  // ------------------------------
  // Control and bus structs
  // ------------------------------

  typedef struct packed {
    logic eq;
    logic lt;
    logic ltu;
  } cond_flags_t;

  typedef struct packed {
    logic inst_en;
    logic fetch;
    logic mem_access;
    logic rf_wen;
    logic pc_en;
  } core_ctrl_t;

  // Wishbone classic master request
  typedef struct packed {
    logic [`CORE_XLEN-1:0] adr;
    logic [`CORE_XLEN-1:0] dat;
    logic [3:0]            sel;
    logic                  we;
    logic                  cyc;
    logic                  stb;
  } wb_req_t;

  typedef struct packed {
    logic [`CORE_XLEN-1:0] dat;
    logic                  ack;
  } wb_rsp_t;

endpackage

//--- design/core_ctrl_fsm.sv
// Core controller
// Steps each instruction through fetch, decode, execute, memory and writeback

`timescale 1ns/1ps

module core_ctrl_fsm (
  input  logic                 clk,
  input  logic                 reset,
  input  core_pkg::opcode_e    opcode,
  input  logic                 ack,
  output core_pkg::core_ctrl_t ctrl
);

  typedef enum logic [2:0] {
    S_RESET,
    S_FETCH,
    S_DECODE,
    S_EXECUTE,
    S_MEMORY,
    S_WRITEBACK
  } state_e;

  state_e state;
  state_e state_next;

  logic is_mem_op;
  logic writes_rd;

  // Only loads and stores touch the bus a second time
  assign is_mem_op = (opcode == core_pkg::LOAD) || (opcode == core_pkg::STORE);
  assign writes_rd = (opcode != core_pkg::STORE) && (opcode != core_pkg::BRANCH);

  // ------------------------------
  // State register
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_RESET;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      S_RESET:     state_next = S_FETCH;
      // Wait for the instruction word
      S_FETCH:     if (ack) state_next = S_DECODE;
      S_DECODE:    state_next = S_EXECUTE;
      S_EXECUTE:   state_next = is_mem_op ? S_MEMORY : S_WRITEBACK;
      // Data cycle held until acknowledged
      S_MEMORY:    if (ack) state_next = S_WRITEBACK;
      S_WRITEBACK: state_next = S_FETCH;
      default:     state_next = S_RESET;
    endcase
  end

  // ------------------------------
  // Control outputs
  // ------------------------------

  assign ctrl.fetch      = (state == S_FETCH);
  assign ctrl.inst_en    = (state == S_FETCH) && ack;
  assign ctrl.mem_access = (state == S_MEMORY);
  assign ctrl.rf_wen     = (state == S_WRITEBACK) && writes_rd;
  // PC moves once per instruction
  assign ctrl.pc_en      = (state == S_WRITEBACK);

endmodule

//--- design/core_pc.sv
// Program counter
// Advances by 4 or takes a branch/jump target once per instruction

`timescale 1ns/1ps
`include "core_config.svh"

module core_pc (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  pc_en,
  input  logic                  redirect,
  input  logic [`CORE_XLEN-1:0] target,
  output logic [`CORE_XLEN-1:0] pc,
  output logic [`CORE_XLEN-1:0] pc_plus4
);

  // Sequential successor, also the JAL link value
  assign pc_plus4 = pc + `CORE_XLEN'd4;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `CORE_RESET_VECTOR;
    end else if (pc_en) begin
      // Taken branch or JAL
      if (redirect) begin
        pc <= target;
      end else begin
        pc <= pc_plus4;
      end
    end
  end

endmodule

//--- design/core_decode.sv
// Instruction decoder
// Holds the fetched word, builds immediates and operands, resolves branches

`timescale 1ns/1ps
`include "core_config.svh"

module core_decode (
  input  logic                        clk,
  input  logic                        inst_en,
  input  logic [`CORE_XLEN-1:0]       inst_word,
  input  logic [`CORE_XLEN-1:0]       pc,
  input  logic [`CORE_XLEN-1:0]       rs1_data,
  input  logic [`CORE_XLEN-1:0]       rs2_data,
  input  core_pkg::cond_flags_t       cond,
  output core_pkg::opcode_e           opcode,
  output logic [`CORE_REG_ADDR_W-1:0] rs1_addr,
  output logic [`CORE_REG_ADDR_W-1:0] rs2_addr,
  output logic [`CORE_REG_ADDR_W-1:0] rd_addr,
  output logic [`CORE_XLEN-1:0]       op_a,
  output logic [`CORE_XLEN-1:0]       op_b,
  output core_pkg::alu_fn_e           alu_fn,
  output core_pkg::load_kind_e        load_kind,
  output core_pkg::wb_sel_e           wb_sel,
  output logic                        redirect,
  output logic [`CORE_XLEN-1:0]       target
);

  core_pkg::inst_u inst;

  logic [`CORE_XLEN-1:0] imm_i;
  logic [`CORE_XLEN-1:0] imm_s;
  logic [`CORE_XLEN-1:0] imm_b;
  logic [`CORE_XLEN-1:0] imm_u;
  logic [`CORE_XLEN-1:0] imm_j;
  logic                  taken;
  logic                  sign;

  // Instruction register, loaded when the fetch is acknowledged
  always_ff @(posedge clk) begin
    if (inst_en) begin
      inst <= inst_word;
    end
  end

  assign opcode   = core_pkg::opcode_e'(inst.r.opcode);
  assign rs1_addr = inst.r.rs1;
  assign rs2_addr = inst.r.rs2;
  assign rd_addr  = inst.r.rd;

  // ------------------------------
  // Immediates
  // ------------------------------

  assign sign  = inst.r.funct7[6];
  assign imm_i = {{20{sign}}, inst.r.funct7, inst.r.rs2};
  assign imm_s = {{20{sign}}, inst.s.imm_hi, inst.s.imm_lo};
  // B type scatters bit 11 into the low imm bit
  assign imm_b = {{19{sign}}, sign, inst.s.imm_lo[0], inst.s.imm_hi[5:0],
                  inst.s.imm_lo[4:1], 1'b0};
  assign imm_u = {inst.r.funct7, inst.r.rs2, inst.r.rs1, inst.r.funct3, 12'b0};
  assign imm_j = {{12{sign}}, inst.r.rs1, inst.r.funct3, inst.r.rs2[0],
                  inst.r.funct7[5:0], inst.r.rs2[4:1], 1'b0};

  // ------------------------------
  // Operands and ALU function
  // ------------------------------

  always_comb begin
    op_a   = rs1_data;
    op_b   = rs2_data;
    alu_fn = core_pkg::ALU_ADD;
    case (opcode)
      core_pkg::OP_IMM, core_pkg::LOAD: op_b = imm_i;
      core_pkg::STORE:                  op_b = imm_s;
      core_pkg::LUI: begin
        op_a = '0;
        op_b = imm_u;
      end
      // Compare only, flags drive the branch
      core_pkg::BRANCH:                 alu_fn = core_pkg::ALU_SUB;
      default: ;
    endcase
    // Register and immediate ALU ops share funct3
    if (opcode == core_pkg::OP || opcode == core_pkg::OP_IMM) begin
      case (inst.r.funct3)
        3'b000: alu_fn = (opcode == core_pkg::OP && inst.r.funct7[5]) ?
                         core_pkg::ALU_SUB : core_pkg::ALU_ADD;
        3'b001: alu_fn = core_pkg::ALU_SLL;
        3'b010: alu_fn = core_pkg::ALU_SLT;
        3'b011: alu_fn = core_pkg::ALU_SLTU;
        3'b100: alu_fn = core_pkg::ALU_XOR;
        3'b101: alu_fn = inst.r.funct7[5] ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
        3'b110: alu_fn = core_pkg::ALU_OR;
        default: alu_fn = core_pkg::ALU_AND;
      endcase
    end
  end

  // Writeback source and load width
  always_comb begin
    case (opcode)
      core_pkg::LOAD: wb_sel = core_pkg::WB_LOAD;
      core_pkg::JAL:  wb_sel = core_pkg::WB_LINK;
      default:        wb_sel = core_pkg::WB_ALU;
    endcase
    case (inst.r.funct3)
      3'b000:  load_kind = core_pkg::LB;
      3'b001:  load_kind = core_pkg::LH;
      3'b100:  load_kind = core_pkg::LBU;
      3'b101:  load_kind = core_pkg::LHU;
      default: load_kind = core_pkg::LW;
    endcase
  end

  // ------------------------------
  // Branch resolution
  // ------------------------------

  always_comb begin
    case (inst.r.funct3)
      3'b000:  taken = cond.eq;
      3'b001:  taken = !cond.eq;
      3'b100:  taken = cond.lt;
      3'b101:  taken = !cond.lt;
      3'b110:  taken = cond.ltu;
      3'b111:  taken = !cond.ltu;
      default: taken = 1'b0;
    endcase
  end

  assign redirect = (opcode == core_pkg::JAL) || ((opcode == core_pkg::BRANCH) && taken);
  assign target   = pc + ((opcode == core_pkg::JAL) ? imm_j : imm_b);

endmodule

//--- design/core_regfile.sv
// Integer register file
// Two combinational read ports, one write port with source select

`timescale 1ns/1ps
`include "core_config.svh"

module core_regfile (
  input  logic                        clk,
  input  logic                        rf_wen,
  input  logic [`CORE_REG_ADDR_W-1:0] waddr,
  input  logic [`CORE_XLEN-1:0]       alu_result,
  input  logic [`CORE_XLEN-1:0]       load_data,
  input  logic [`CORE_XLEN-1:0]       link,
  input  core_pkg::wb_sel_e           wb_sel,
  input  logic [`CORE_REG_ADDR_W-1:0] raddr0,
  input  logic [`CORE_REG_ADDR_W-1:0] raddr1,
  output logic [`CORE_XLEN-1:0]       rdata0,
  output logic [`CORE_XLEN-1:0]       rdata1
);

  logic [`CORE_XLEN-1:0] regs [0:`CORE_NUM_REGS-1];
  logic [`CORE_XLEN-1:0] wdata;

  // Writeback mux
  always_comb begin
    case (wb_sel)
      core_pkg::WB_LOAD: wdata = load_data;
      core_pkg::WB_LINK: wdata = link;
      default:           wdata = alu_result;
    endcase
  end

  // x0 is never written
  always_ff @(posedge clk) begin
    if (rf_wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 always reads zero
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

//--- design/core_alu.sv
// Integer ALU
// Arithmetic, logic and shift result plus the branch compare flags

`timescale 1ns/1ps
`include "core_config.svh"

module core_alu (
  input  logic [`CORE_XLEN-1:0] op_a,
  input  logic [`CORE_XLEN-1:0] op_b,
  input  core_pkg::alu_fn_e     alu_fn,
  output logic [`CORE_XLEN-1:0] result,
  output core_pkg::cond_flags_t cond
);

  logic [`CORE_XLEN-1:0] diff;
  logic [4:0]            shamt;
  logic                  diff_signs;

  assign diff  = op_a - op_b;
  assign shamt = op_b[4:0];

  // ------------------------------
  // Compare flags
  // ------------------------------

  // With differing signs the subtraction can overflow,
  // so the operand sign bits decide instead
  assign diff_signs = op_a[`CORE_XLEN-1] ^ op_b[`CORE_XLEN-1];
  assign cond.eq    = (diff == '0);
  assign cond.lt    = diff_signs ? op_a[`CORE_XLEN-1] : diff[`CORE_XLEN-1];
  assign cond.ltu   = diff_signs ? op_b[`CORE_XLEN-1] : diff[`CORE_XLEN-1];

  // ------------------------------
  // Result
  // ------------------------------

  always_comb begin
    case (alu_fn)
      core_pkg::ALU_SUB:  result = diff;
      core_pkg::ALU_AND:  result = op_a & op_b;
      core_pkg::ALU_OR:   result = op_a | op_b;
      core_pkg::ALU_XOR:  result = op_a ^ op_b;
      // Set-less-than reuses the branch flags
      core_pkg::ALU_SLT:  result = {{(`CORE_XLEN-1){1'b0}}, cond.lt};
      core_pkg::ALU_SLTU: result = {{(`CORE_XLEN-1){1'b0}}, cond.ltu};
      core_pkg::ALU_SLL:  result = op_a << shamt;
      core_pkg::ALU_SRL:  result = op_a >> shamt;
      core_pkg::ALU_SRA:  result = $signed(op_a) >>> shamt;
      // Add, also address generation and LUI
      default:            result = op_a + op_b;
    endcase
  end

endmodule

//--- design/core_bus_master.sv
// Wishbone classic master
// Fetch and data requests on one port, registered load extraction

`timescale 1ns/1ps
`include "core_config.svh"

module core_bus_master (
  input  logic                  clk,
  input  core_pkg::core_ctrl_t  ctrl,
  input  logic [`CORE_XLEN-1:0] pc,
  input  logic [`CORE_XLEN-1:0] addr,
  input  logic [`CORE_XLEN-1:0] store_data,
  input  core_pkg::opcode_e     opcode,
  input  core_pkg::load_kind_e  load_kind,
  output core_pkg::wb_req_t     wb_req,
  input  core_pkg::wb_rsp_t     wb_rsp,
  output logic [`CORE_XLEN-1:0] load_data
);

  logic [7:0]            lane_b;
  logic [15:0]           lane_h;
  logic [`CORE_XLEN-1:0] extracted;

  // ------------------------------
  // Request
  // ------------------------------

  // Inputs are steady for the whole state, so the request holds until ack
  assign wb_req.cyc = ctrl.fetch || ctrl.mem_access;
  assign wb_req.stb = ctrl.fetch || ctrl.mem_access;
  assign wb_req.adr = ctrl.fetch ? pc : {addr[`CORE_XLEN-1:2], 2'b00};
  assign wb_req.dat = store_data;
  assign wb_req.we  = ctrl.mem_access && (opcode == core_pkg::STORE);
  // Full words only
  assign wb_req.sel = 4'hf;

  // ------------------------------
  // Load extraction
  // ------------------------------

  assign lane_b = wb_rsp.dat[{addr[1:0], 3'b000} +: 8];
  assign lane_h = addr[1] ? wb_rsp.dat[31:16] : wb_rsp.dat[15:0];

  always_comb begin
    case (load_kind)
      core_pkg::LB:  extracted = {{24{lane_b[7]}}, lane_b};
      core_pkg::LBU: extracted = {24'b0, lane_b};
      core_pkg::LH:  extracted = {{16{lane_h[15]}}, lane_h};
      core_pkg::LHU: extracted = {16'b0, lane_h};
      default:       extracted = wb_rsp.dat;
    endcase
  end

  // Captured at the end of the data cycle, used in writeback
  always_ff @(posedge clk) begin
    if (ctrl.mem_access && wb_rsp.ack) begin
      load_data <= extracted;
    end
  end

endmodule

//--- design/core_top.sv
// Multi-cycle RV32I core
// One Wishbone classic master port shared by fetch and data access

`timescale 1ns/1ps
`include "core_config.svh"

module core_top (
  input  logic             clk,
  input  logic             reset,
  output core_pkg::wb_req_t wb_req,
  input  core_pkg::wb_rsp_t wb_rsp
);

  core_pkg::core_ctrl_t  ctrl;
  core_pkg::opcode_e     opcode;
  core_pkg::alu_fn_e     alu_fn;
  core_pkg::load_kind_e  load_kind;
  core_pkg::wb_sel_e     wb_sel;
  core_pkg::cond_flags_t cond;

  logic [`CORE_XLEN-1:0]       pc;
  logic [`CORE_XLEN-1:0]       pc_plus4;
  logic [`CORE_XLEN-1:0]       target;
  logic                        redirect;
  logic [`CORE_REG_ADDR_W-1:0] rs1_addr;
  logic [`CORE_REG_ADDR_W-1:0] rs2_addr;
  logic [`CORE_REG_ADDR_W-1:0] rd_addr;
  logic [`CORE_XLEN-1:0]       rs1_data;
  logic [`CORE_XLEN-1:0]       rs2_data;
  logic [`CORE_XLEN-1:0]       op_a;
  logic [`CORE_XLEN-1:0]       op_b;
  logic [`CORE_XLEN-1:0]       alu_result;
  logic [`CORE_XLEN-1:0]       load_data;

  // Sequencer
  core_ctrl_fsm ctrl_fsm (
    .clk    (clk),
    .reset  (reset),
    .opcode (opcode),
    .ack    (wb_rsp.ack),
    .ctrl   (ctrl)
  );

  core_pc pc_reg (
    .clk      (clk),
    .reset    (reset),
    .pc_en    (ctrl.pc_en),
    .redirect (redirect),
    .target   (target),
    .pc       (pc),
    .pc_plus4 (pc_plus4)
  );

  // Instruction comes straight off the bus during fetch
  core_decode decode (
    .clk       (clk),
    .inst_en   (ctrl.inst_en),
    .inst_word (wb_rsp.dat),
    .pc        (pc),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .cond      (cond),
    .opcode    (opcode),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .rd_addr   (rd_addr),
    .op_a      (op_a),
    .op_b      (op_b),
    .alu_fn    (alu_fn),
    .load_kind (load_kind),
    .wb_sel    (wb_sel),
    .redirect  (redirect),
    .target    (target)
  );

  // Link value is the old pc plus 4, still valid in writeback
  core_regfile regfile (
    .clk        (clk),
    .rf_wen     (ctrl.rf_wen),
    .waddr      (rd_addr),
    .alu_result (alu_result),
    .load_data  (load_data),
    .link       (pc_plus4),
    .wb_sel     (wb_sel),
    .raddr0     (rs1_addr),
    .raddr1     (rs2_addr),
    .rdata0     (rs1_data),
    .rdata1     (rs2_data)
  );

  core_alu alu (
    .op_a   (op_a),
    .op_b   (op_b),
    .alu_fn (alu_fn),
    .result (alu_result),
    .cond   (cond)
  );

  // ALU sum doubles as the data address
  core_bus_master bus_master (
    .clk        (clk),
    .ctrl       (ctrl),
    .pc         (pc),
    .addr       (alu_result),
    .store_data (rs2_data),
    .opcode     (opcode),
    .load_kind  (load_kind),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .load_data  (load_data)
  );

endmodule

//--- sim/core_clock_gen.sv
// Testbench clock and reset
// 20 ns clock, reset held high for the first 10 cycles

`timescale 1ns/1ps

module core_clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

//--- sim/core_assertions.sv
// Wishbone protocol checks
// Bound to the core top level, watches the shared master port

`timescale 1ns/1ps
`include "core_config.svh"

module core_assertions (
  input logic              clk,
  input logic              reset,
  input core_pkg::wb_req_t wb_req,
  input core_pkg::wb_rsp_t wb_rsp
);

  // Bus idle while in reset
  reset_idle: assert property (@(posedge clk) reset |=> !wb_req.cyc && !wb_req.stb)
    else $error("bus not idle after reset cycle");

  // First request is a fetch from the reset vector
  first_fetch: assert property (@(posedge clk)
    $fell(reset) |-> !wb_req.cyc ##1
      (wb_req.cyc && !wb_req.we && wb_req.adr == `CORE_RESET_VECTOR))
    else $error("first request is not a fetch at the reset vector");

  // ------------------------------
  // Classic cycle rules
  // ------------------------------

  stb_matches_cyc: assert property (@(posedge clk) disable iff (reset)
    wb_req.stb == wb_req.cyc)
    else $error("stb differs from cyc");

  // Request held until acknowledged
  held_until_ack: assert property (@(posedge clk) disable iff (reset)
    wb_req.cyc && !wb_rsp.ack |=>
      wb_req.cyc && $stable(wb_req.adr) && $stable(wb_req.dat) && $stable(wb_req.we))
    else $error("request changed before ack");

  // Cycle ends right after ack, so every fetch starts on a fresh cycle
  drop_after_ack: assert property (@(posedge clk) disable iff (reset)
    wb_req.cyc && wb_rsp.ack |=> !wb_req.cyc)
    else $error("cyc still high after ack");

  full_word_sel: assert property (@(posedge clk) disable iff (reset)
    wb_req.cyc |-> wb_req.sel == 4'hf)
    else $error("sel not all ones");

  word_aligned: assert property (@(posedge clk) disable iff (reset)
    wb_req.cyc |-> wb_req.adr[1:0] == 2'b00)
    else $error("bus address not word aligned");

endmodule

bind core_top core_assertions bus_checks (
  .clk    (clk),
  .reset  (reset),
  .wb_req (wb_req),
  .wb_rsp (wb_rsp)
);

//--- sim/core_tb.sv
// Core testbench
// Memory model with random wait states, encoded program and store checks

`timescale 1ns/1ps
`include "core_config.svh"

module core_tb;

  // Far above the worst case of about 1550 cycles for this program
  localparam int TIMEOUT_CYCLES = 4000;

  logic              clk;
  logic              reset;
  core_pkg::wb_req_t wb_req;
  core_pkg::wb_rsp_t wb_rsp;

  logic [31:0] prog [$];
  logic [31:0] dmem [logic [31:0]];
  logic [31:0] exp_adr [$];
  logic [31:0] exp_dat [$];
  logic [31:0] rng;
  logic [31:0] halt_pc;
  logic [1:0]  wait_left;
  logic        busy;
  int          store_k;
  int          halt_seen;
  int          cycles;

  core_clock_gen clock_gen (.clk(clk), .reset(reset));

  core_top dut0 (.clk(clk), .reset(reset), .wb_req(wb_req), .wb_rsp(wb_rsp));

  // ------------------------------
  // Helpers and encoders
  // ------------------------------

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  // SW only
  function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // Reference ALU from the RV32I rules
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: if (alt) r = a - b; else r = a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'b0, $signed(a) < $signed(b)};
      3'd3: r = {31'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: if (alt) r = $signed(a) >>> b[4:0]; else r = a >> b[4:0];
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] cur_pc();
    return `CORE_RESET_VECTOR + 32'(4 * prog.size());
  endfunction

  // Store rs2 into the next result slot and queue the expected word
  task automatic store_result(input logic [4:0] rs2, input logic [31:0] value);
    logic [31:0] addr;
    addr = 32'h200 + 32'(4 * store_k);
    prog.push_back(enc_sw(addr[11:0], rs2, 5'd0));
    exp_adr.push_back(addr);
    exp_dat.push_back(value);
    store_k++;
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  // ------------------------------
  // Program
  // ------------------------------

  task automatic build_program();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] w;
    logic [31:0] imm;
    logic [31:0] v;
    logic [2:0]  f3s [6];
    logic [31:0] loop_pc;
    int          ra [3];
    int          rb [3];
    a = next_rand();
    b = next_rand();
    w = next_rand();
    dmem[32'h100] = a;
    dmem[32'h104] = b;
    dmem[32'h108] = w;
    prog.push_back(enc_i(12'h100, 5'd0, 3'b010, 5'd1, 7'b0000011));
    prog.push_back(enc_i(12'h104, 5'd0, 3'b010, 5'd2, 7'b0000011));
    // Register ops including sub and sra
    for (int f = 0; f < 10; f++) begin
      prog.push_back(enc_r((f >= 8) ? 7'h20 : 7'h00, 5'd2, 5'd1,
                           (f == 9) ? 3'd5 : 3'(f), 5'd3));
      store_result(5'd3, alu_ref((f == 9) ? 3'd5 : 3'(f), f >= 8, a, b));
    end
    // Immediate ops with f3 5 as srai
    for (int f = 0; f < 8; f++) begin
      imm = next_rand() & 32'hfff;
      if (f == 1) imm = {27'b0, imm[4:0]};
      if (f == 5) imm = {20'b0, 7'h20, imm[4:0]};
      imm = {{20{imm[11]}}, imm[11:0]};
      prog.push_back(enc_i(imm[11:0], 5'd1, 3'(f), 5'd3, 7'b0010011));
      store_result(5'd3, alu_ref(3'(f), f == 5, a, imm));
    end
    v = next_rand();
    prog.push_back({v[31:12], 5'd3, 7'b0110111});
    store_result(5'd3, {v[31:12], 12'b0});
    // Subword loads on every lane
    for (int off = 0; off < 4; off++) begin
      v = w >> (8 * off);
      prog.push_back(enc_i(12'(32'h108 + off), 5'd0, 3'b000, 5'd3, 7'b0000011));
      store_result(5'd3, {{24{v[7]}}, v[7:0]});
      prog.push_back(enc_i(12'(32'h108 + off), 5'd0, 3'b100, 5'd3, 7'b0000011));
      store_result(5'd3, {24'b0, v[7:0]});
      if (off % 2 == 0) begin
        prog.push_back(enc_i(12'(32'h108 + off), 5'd0, 3'b001, 5'd3, 7'b0000011));
        store_result(5'd3, {{16{v[15]}}, v[15:0]});
        prog.push_back(enc_i(12'(32'h108 + off), 5'd0, 3'b101, 5'd3, 7'b0000011));
        store_result(5'd3, {16'b0, v[15:0]});
      end
    end
    // Each branch type with swapped and equal operands
    f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    ra = '{1, 2, 1};
    rb = '{2, 1, 1};
    foreach (f3s[i]) begin
      for (int p = 0; p < 3; p++) begin
        prog.push_back(enc_i(12'd1, 5'd0, 3'b000, 5'd6, 7'b0010011));
        prog.push_back(enc_b(13'd8, 5'(rb[p]), 5'(ra[p]), f3s[i]));
        prog.push_back(enc_i(12'd2, 5'd0, 3'b000, 5'd6, 7'b0010011));
        store_result(5'd6, branch_ref(f3s[i], (ra[p] == 1) ? a : b,
                                      (rb[p] == 1) ? a : b) ? 32'd1 : 32'd2);
      end
    end
    // Countdown loop from 3
    prog.push_back(enc_i(12'd3, 5'd0, 3'b000, 5'd7, 7'b0010011));
    loop_pc = cur_pc();
    prog.push_back(enc_i(12'hfff, 5'd7, 3'b000, 5'd7, 7'b0010011));
    prog.push_back(enc_sw(12'h400, 5'd7, 5'd0));
    prog.push_back(enc_b(13'(loop_pc - cur_pc()), 5'd0, 5'd7, 3'd1));
    for (int n = 2; n >= 0; n--) begin
      exp_adr.push_back(32'h400);
      exp_dat.push_back(32'(n));
    end
    // JAL over one instruction then store the link
    v = cur_pc();
    prog.push_back(enc_j(21'd8, 5'd8));
    prog.push_back(enc_i(12'd0, 5'd0, 3'b000, 5'd8, 7'b0010011));
    prog.push_back(enc_sw(12'h404, 5'd8, 5'd0));
    exp_adr.push_back(32'h404);
    exp_dat.push_back(v + 32'd4);
    halt_pc = cur_pc();
    prog.push_back(enc_j(21'd0, 5'd0));
  endtask

  // ------------------------------
  // Memory model
  // ------------------------------

  task automatic respond();
    logic [31:0] adr;
    adr = wb_req.adr;
    wb_rsp.ack <= 1'b1;
    if (wb_req.we) begin
      if (exp_adr.size() == 0) begin
        report_failure($sformatf("unexpected store to address %h", adr));
      end else begin
        assert (adr == exp_adr[0]) else
          report_failure($sformatf("error wb_req.adr: got %h expected %h", adr, exp_adr[0]));
        assert (wb_req.dat == exp_dat[0]) else
          report_failure($sformatf("error wb_req.dat: got %h expected %h",
                                   wb_req.dat, exp_dat[0]));
        void'(exp_adr.pop_front());
        void'(exp_dat.pop_front());
        dmem[adr] = wb_req.dat;
      end
    end else if (adr >= `CORE_RESET_VECTOR && (adr - `CORE_RESET_VECTOR) / 4 < prog.size()) begin
      wb_rsp.dat <= prog[(adr - `CORE_RESET_VECTOR) / 4];
      if (adr == halt_pc) halt_seen++;
    end else if (dmem.exists(adr)) begin
      wb_rsp.dat <= dmem[adr];
    end else begin
      // Unwritten words get a pattern of the full address
      wb_rsp.dat <= ~adr ^ {adr[15:0], adr[31:16]};
    end
  endtask

  always @(posedge clk) begin : memory_model
    logic [1:0] w;
    if (reset) begin
      wb_rsp.ack <= 1'b0;
      busy       <= 1'b0;
    end else if (wb_rsp.ack) begin
      wb_rsp.ack <= 1'b0;
    end else if (wb_req.cyc && wb_req.stb) begin
      if (!busy) begin
        w = 2'(next_rand() % 4);
        if (w == 0) begin
          respond();
        end else begin
          busy      <= 1'b1;
          wait_left <= w - 2'd1;
        end
      end else if (wait_left == 0) begin
        busy <= 1'b0;
        respond();
      end else begin
        wait_left <= wait_left - 2'd1;
      end
    end
  end

  // ------------------------------
  // Run control
  // ------------------------------

  initial begin
    wb_rsp    = '0;
    busy      = 1'b0;
    wait_left = '0;
    rng       = 32'he032;
    store_k   = 0;
    halt_seen = 0;
    cycles    = 0;
    build_program();
    // Halt loop fetched twice marks the end
    while (halt_seen < 2 && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    if (halt_seen < 2) begin
      report_failure("timeout: program did not reach its final jump");
    end else if (exp_adr.size() != 0) begin
      report_failure($sformatf("%0d expected stores never happened", exp_adr.size()));
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

//--- sim.f
+incdir+design
design/core_pkg.sv
design/core_ctrl_fsm.sv
design/core_pc.sv
design/core_decode.sv
design/core_regfile.sv
design/core_alu.sv
design/core_bus_master.sv
design/core_top.sv
sim/core_clock_gen.sv
sim/core_assertions.sv
sim/core_tb.sv
